/* verilog/decode_pkg.sv */
package decode_pkg;

    // RV32 major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        LUI      = 7'b0110111,
        AUIPC    = 7'b0010111,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        BRANCH   = 7'b1100011,
        LOAD     = 7'b0000011,
        STORE    = 7'b0100011,
        OP_IMM   = 7'b0010011,
        OP       = 7'b0110011,
        LOAD_FP  = 7'b0000111,
        STORE_FP = 7'b0100111,
        FMADD    = 7'b1000011,
        FMSUB    = 7'b1000111,
        FNMSUB   = 7'b1001011,
        FNMADD   = 7'b1001111,
        OP_FP    = 7'b1010011,
        SYSTEM   = 7'b1110011
    } opcode_e;

    // Immediate format
    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_sel_e;

    // Kind of PC-relative target
    typedef enum logic {
        TGT_JAL,
        TGT_BRANCH
    } target_sel_e;

    // Writeback packet, destination taken from inst[11:7]
    typedef struct packed {
        logic        regwen;
        logic        fpregwen;
        logic [31:0] inst;
        logic [31:0] wdata;
    } wb_t;

    // Decode to execute bundle
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] rd1;
        logic [31:0] rd2;
        logic [31:0] fd1;
        logic [31:0] fd2;
        logic [31:0] fd3;
        logic [31:0] imm;
        logic        br_taken;
    } id_ex_t;

    // addi x0, x0, 0
    localparam logic [31:0] NOP = 32'h0000_0013;

endpackage

/* verilog/reg_file.sv */
module reg_file (
    input  logic        clk,
    input  logic        we,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] mem [32];

    // x0 is never stored
    always_ff @(posedge clk) begin
        if (we && (wa != 5'd0)) begin
            mem[wa] <= wd;
        end
    end

    // Combinational read with write-first bypass
    function automatic logic [31:0] read_port(input logic [4:0] ra);
        logic [31:0] data;
        if (ra == 5'd0) begin
            data = 32'd0;
        end else if (we && (wa == ra)) begin
            data = wd;
        end else begin
            data = mem[ra];
        end
        return data;
    endfunction

    always_comb begin
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
    end

endmodule

/* verilog/fp_reg_file.sv */
module fp_reg_file (
    input  logic        clk,
    input  logic        we,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  ra3,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    output logic [31:0] rd3
);

    logic [31:0] mem [32];

    // Every entry writable, f0 included
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wa] <= wd;
        end
    end

    // Same-cycle write wins over the stored word
    function automatic logic [31:0] read_port(input logic [4:0] ra);
        logic [31:0] data;
        if (we && (wa == ra)) begin
            data = wd;
        end else begin
            data = mem[ra];
        end
        return data;
    endfunction

    // Third port feeds the rs3 operand of the fused multiply-add forms
    always_comb begin
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
        rd3 = read_port(ra3);
    end

endmodule

/* verilog/imm_gen.sv */
module imm_gen (
    input  logic [31:0]          inst,
    input  decode_pkg::imm_sel_e sel,
    output logic [31:0]          imm
);

    import decode_pkg::*;

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (sel)
            IMM_S: begin
                imm = {{20{sign}}, inst[31:25], inst[11:7]};
            end
            // Branch offsets are always even
            IMM_B: begin
                imm = {{19{sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            // Upper 20 bits, low 12 cleared
            IMM_U: begin
                imm = {inst[31:12], 12'd0};
            end
            IMM_J: begin
                imm = {{11{sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            // I format, also the fallback for unused encodings
            default: begin
                imm = {{20{sign}}, inst[31:20]};
            end
        endcase
    end

endmodule

/* verilog/target_gen.sv */
module target_gen (
    input  logic [31:0]             pc,
    input  logic [31:0]             imm,
    input  decode_pkg::target_sel_e sel,
    input  logic                    en,
    output logic [31:0]             target,
    output logic                    target_taken,
    output logic                    branch_taken
);

    import decode_pkg::*;

    logic backward;

    // Fetch uses the target only when target_taken is set
    assign target = pc + imm;

    // Negative offset means a backward branch
    assign backward = imm[31];

    // Jumps and backward branches predicted taken
    always_comb begin
        branch_taken = 1'b0;
        target_taken = 1'b0;
        if (en) begin
            case (sel)
                TGT_JAL: begin
                    target_taken = 1'b1;
                end
                TGT_BRANCH: begin
                    branch_taken = backward;
                    target_taken = backward;
                end
            endcase
        end
    end

endmodule

/* verilog/id_control.sv */
module id_control (
    input  logic [31:0]             inst,
    input  logic [31:0]             ex_inst,
    output decode_pkg::imm_sel_e    imm_sel,
    output decode_pkg::target_sel_e target_sel,
    output logic                    target_en,
    output logic                    stall
);

    import decode_pkg::*;

    opcode_e    op;
    opcode_e    ex_op;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rs3;
    logic [4:0] ex_rd;

    logic use_rs1;
    logic use_rs2;
    logic use_fs1;
    logic use_fs2;
    logic use_fs3;
    logic int_hit;
    logic fp_hit;

    assign op    = opcode_e'(inst[6:0]);
    assign ex_op = opcode_e'(ex_inst[6:0]);
    assign rs1   = inst[19:15];
    assign rs2   = inst[24:20];
    assign rs3   = inst[31:27];
    assign ex_rd = ex_inst[11:7];

    // Immediate format and target kind
    always_comb begin
        case (op)
            LUI, AUIPC:      imm_sel = IMM_U;
            JAL:             imm_sel = IMM_J;
            BRANCH:          imm_sel = IMM_B;
            STORE, STORE_FP: imm_sel = IMM_S;
            default:         imm_sel = IMM_I;
        endcase
    end

    assign target_sel = (op == BRANCH) ? TGT_BRANCH : TGT_JAL;

    // JALR depends on rs1, so it is left to execute
    assign target_en = (op == JAL) || (op == BRANCH);

    // Which source fields are live in each register file
    always_comb begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b0;
        use_fs1 = 1'b0;
        use_fs2 = 1'b0;
        use_fs3 = 1'b0;
        case (op)
            LUI, AUIPC, JAL: begin
                use_rs1 = 1'b0;
            end
            BRANCH, STORE, OP: begin
                use_rs2 = 1'b1;
            end
            FMADD, FMSUB, FNMSUB, FNMADD: begin
                use_rs1 = 1'b0;
                use_fs1 = 1'b1;
                use_fs2 = 1'b1;
                use_fs3 = 1'b1;
            end
            // Moves and conversions may read integer rs1, so it stays live
            OP_FP: begin
                use_fs1 = 1'b1;
                use_fs2 = 1'b1;
            end
            STORE_FP: begin
                use_fs2 = 1'b1;
            end
            default: begin
                use_rs1 = 1'b1;
            end
        endcase
    end

    // Load in execute whose result is needed now
    assign int_hit = (ex_op == LOAD) && (ex_rd != 5'd0) &&
                     ((use_rs1 && (rs1 == ex_rd)) || (use_rs2 && (rs2 == ex_rd)));

    // f0 is a real register, no zero check here
    assign fp_hit = (ex_op == LOAD_FP) &&
                    ((use_fs1 && (rs1 == ex_rd)) ||
                     (use_fs2 && (rs2 == ex_rd)) ||
                     (use_fs3 && (rs3 == ex_rd)));

    assign stall = int_hit || fp_hit;

endmodule

/* verilog/id_stage.sv */
module id_stage #(
    parameter int BOOT_SEL_BIT = 30
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mem_flush,
    input  logic               ex_stall,
    input  logic [31:0]        id_pc,
    input  logic [31:0]        id_bios_inst,
    input  logic [31:0]        id_imem_inst,
    input  decode_pkg::wb_t    wb,
    output logic [31:0]        id_target,
    output logic               id_target_taken,
    output logic               id_stall,
    output decode_pkg::id_ex_t ex
);

    import decode_pkg::*;

    localparam id_ex_t BUBBLE = '{inst: NOP, default: '0};

    logic [31:0] id_inst;
    logic [4:0]  ra1;
    logic [4:0]  ra2;
    logic [4:0]  ra3;
    logic [4:0]  wa;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] fd1;
    logic [31:0] fd2;
    logic [31:0] fd3;
    logic [31:0] imm;
    logic        br_taken;

    imm_sel_e    imm_sel;
    target_sel_e target_sel;
    logic        target_en;
    id_ex_t      id_bundle;

    // Boot ROM below the select bit, instruction memory above
    assign id_inst = id_pc[BOOT_SEL_BIT] ? id_imem_inst : id_bios_inst;

    assign ra1 = id_inst[19:15];
    assign ra2 = id_inst[24:20];
    assign ra3 = id_inst[31:27];
    assign wa  = wb.inst[11:7];

    reg_file u_reg_file (
        .clk (clk),
        .we  (wb.regwen),
        .ra1 (ra1),
        .ra2 (ra2),
        .wa  (wa),
        .wd  (wb.wdata),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    fp_reg_file u_fp_reg_file (
        .clk (clk),
        .we  (wb.fpregwen),
        .ra1 (ra1),
        .ra2 (ra2),
        .ra3 (ra3),
        .wa  (wa),
        .wd  (wb.wdata),
        .rd1 (fd1),
        .rd2 (fd2),
        .rd3 (fd3)
    );

    imm_gen u_imm_gen (
        .inst (id_inst),
        .sel  (imm_sel),
        .imm  (imm)
    );

    target_gen u_target_gen (
        .pc           (id_pc),
        .imm          (imm),
        .sel          (target_sel),
        .en           (target_en),
        .target       (id_target),
        .target_taken (id_target_taken),
        .branch_taken (br_taken)
    );

    // Hazard check against the instruction now in execute
    id_control u_id_control (
        .inst       (id_inst),
        .ex_inst    (ex.inst),
        .imm_sel    (imm_sel),
        .target_sel (target_sel),
        .target_en  (target_en),
        .stall      (id_stall)
    );

    assign id_bundle = '{
        pc:       id_pc,
        inst:     id_inst,
        rd1:      rd1,
        rd2:      rd2,
        fd1:      fd1,
        fd2:      fd2,
        fd3:      fd3,
        imm:      imm,
        br_taken: br_taken
    };

    // Flush beats back-pressure, back-pressure beats the load-use bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex <= BUBBLE;
        end else if (mem_flush) begin
            ex <= BUBBLE;
        end else if (!ex_stall) begin
            ex <= id_stall ? BUBBLE : id_bundle;
        end
    end

endmodule

/* tb/tb_decode_tests.svh */
`ifndef TB_DECODE_TESTS_SVH
`define TB_DECODE_TESTS_SVH

// Instruction encoders taking the sign-extended immediate
function automatic logic [31:0] enc_r(input logic [4:0] rs2, input logic [4:0] rs1,
                                      input logic [4:0] rd, input opcode_e op);
    return {7'd0, rs2, rs1, 3'b000, rd, op};
endfunction

function automatic logic [31:0] enc_r4(input logic [4:0] rs3, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [4:0] rd,
                                       input opcode_e op);
    return {rs3, 2'b00, rs2, rs1, 3'b000, rd, op};
endfunction

function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                      input logic [4:0] rd, input opcode_e op);
    return {imm[11:0], rs1, 3'b010, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input opcode_e op);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op};
endfunction

function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[31:12], rd, LUI};
endfunction

function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
endfunction

function automatic id_ex_t bubble();
    id_ex_t b;
    b      = '0;
    b.inst = {12'd0, 5'd0, 3'b000, 5'd0, OP_IMM};
    return b;
endfunction

// Operands come from the model at the fields rs1, rs2 and rs3
function automatic id_ex_t expect_bundle(input logic [31:0] pc, input logic [31:0] inst,
                                         input logic [31:0] imm, input logic br_taken);
    id_ex_t b;
    b.pc       = pc;
    b.inst     = inst;
    b.rd1      = int_model[inst[19:15]];
    b.rd2      = int_model[inst[24:20]];
    b.fd1      = fp_model[inst[19:15]];
    b.fd2      = fp_model[inst[24:20]];
    b.fd3      = fp_model[inst[31:27]];
    b.imm      = imm;
    b.br_taken = br_taken;
    return b;
endfunction

// Caller sits on a falling edge
task automatic present(input logic [31:0] pc, input logic [31:0] inst);
    id_pc        = pc;
    id_bios_inst = inst;
    id_imem_inst = inst;
endtask

task automatic write_reg(input logic fp, input logic [4:0] idx, input logic [31:0] data);
    wb          = '0;
    wb.inst     = {20'd0, idx, 7'd0};
    wb.wdata    = data;
    wb.regwen   = ~fp;
    wb.fpregwen = fp;
    @(negedge clk);
    if (fp) begin
        fp_model[idx] = data;
    end else if (idx != 5'd0) begin
        int_model[idx] = data;
    end
    wb = '0;
endtask

task automatic test_reset_and_regs();
    check_bundle(ex, bubble(), "bundle after reset");
    for (int i = 0; i < 32; i++) begin
        write_reg(1'b0, i[4:0], $random(seed));
        write_reg(1'b1, i[4:0], $random(seed));
    end
    present(32'h0000_0100, enc_r(5'd2, 5'd1, 5'd3, OP));
    @(negedge clk);
    check_word(ex.rd1, int_model[1], "ADD rd1");
    check_word(ex.rd2, int_model[2], "ADD rd2");
    present(32'h0000_0104, enc_r4(5'd3, 5'd2, 5'd1, 5'd4, FMADD));
    @(negedge clk);
    check_word(ex.fd1, fp_model[1], "FMADD fd1");
    check_word(ex.fd2, fp_model[2], "FMADD fd2");
    check_word(ex.fd3, fp_model[3], "FMADD fd3");
    // x0 was written above and still reads zero
    present(32'h0000_0108, enc_r(5'd4, 5'd0, 5'd3, OP));
    @(negedge clk);
    check_word(ex.rd1, 32'd0, "x0 read");
    present(32'h0000_010c, enc_r4(5'd3, 5'd2, 5'd0, 5'd1, FMADD));
    @(negedge clk);
    check_word(ex.fd1, fp_model[0], "f0 read");
    // Write and read of the same register in one cycle
    present(32'h0000_0110, enc_r(5'd7, 5'd7, 5'd3, OP));
    write_reg(1'b0, 5'd7, $random(seed));
    check_word(ex.rd1, int_model[7], "x7 bypass");
    present(32'h0000_0114, enc_r4(5'd7, 5'd2, 5'd1, 5'd4, FMADD));
    write_reg(1'b1, 5'd7, $random(seed));
    check_word(ex.fd3, fp_model[7], "f7 bypass");
endtask

task automatic check_imm(input logic [31:0] inst, input logic [31:0] exp, input string what);
    present(32'h0000_1000, inst);
    @(negedge clk);
    check_word(ex.imm, exp, what);
endtask

task automatic test_immediates();
    check_imm(enc_i(2047, 5'd1, 5'd2, OP_IMM), 2047, "I imm positive");
    check_imm(enc_i(-5, 5'd1, 5'd2, OP_IMM), -5, "I imm negative");
    check_imm(enc_s(100, 5'd3, 5'd1, STORE), 100, "S imm positive");
    check_imm(enc_s(-300, 5'd3, 5'd1, STORE), -300, "S imm negative");
    check_imm(enc_b(1000, 5'd3, 5'd1), 1000, "B imm positive");
    check_imm(enc_b(-2000, 5'd3, 5'd1), -2000, "B imm negative");
    check_imm(enc_u(32'h1234_5000, 5'd7), 32'h1234_5000, "U imm positive");
    check_imm(enc_u(32'habcd_e000, 5'd7), 32'habcd_e000, "U imm negative");
    check_imm(enc_j(32'h000a_bcde, 5'd1), 32'h000a_bcde, "J imm positive");
    check_imm(enc_j(-262144, 5'd1), -262144, "J imm negative");
endtask

task automatic test_targets();
    logic [31:0] pc;
    pc = 32'h0000_2000;
    present(pc, enc_j(32'h0000_0800, 5'd1));
    #1;
    check_word(id_target, pc + 32'h800, "JAL target");
    check_bit(id_target_taken, 1'b1, "JAL redirect");
    @(negedge clk);
    check_bit(ex.br_taken, 1'b0, "JAL br_taken");
    present(pc + 4, enc_b(-16, 5'd2, 5'd1));
    #1;
    check_word(id_target, pc + 4 - 16, "backward branch target");
    check_bit(id_target_taken, 1'b1, "backward branch redirect");
    @(negedge clk);
    check_bit(ex.br_taken, 1'b1, "backward branch br_taken");
    present(pc + 8, enc_b(32, 5'd2, 5'd1));
    #1;
    check_bit(id_target_taken, 1'b0, "forward branch redirect");
    @(negedge clk);
    check_bit(ex.br_taken, 1'b0, "forward branch br_taken");
    // Negative offset so that a JALR treated as a branch would predict taken
    present(pc + 12, enc_i(-8, 5'd1, 5'd1, JALR));
    #1;
    check_bit(id_target_taken, 1'b0, "JALR redirect");
    @(negedge clk);
    check_bit(ex.br_taken, 1'b0, "JALR br_taken");
endtask

task automatic test_inst_source();
    logic [31:0] bios;
    logic [31:0] imem;
    bios         = enc_i(5, 5'd2, 5'd1, OP_IMM);
    imem         = enc_i(-7, 5'd4, 5'd3, OP_IMM);
    id_bios_inst = bios;
    id_imem_inst = imem;
    id_pc        = 32'h0000_0040;
    @(negedge clk);
    check_bundle(ex, expect_bundle(32'h0000_0040, bios, 5, 1'b0), "boot ROM word");
    id_pc = 32'h4000_0080;
    @(negedge clk);
    check_bundle(ex, expect_bundle(32'h4000_0080, imem, -7, 1'b0), "imem word");
endtask

task automatic test_load_use();
    logic [31:0] add_inst;
    logic [31:0] fma_inst;
    add_inst = enc_r(5'd7, 5'd5, 5'd6, OP);
    fma_inst = enc_r4(5'd9, 5'd2, 5'd1, 5'd10, FMADD);
    present(32'h0000_3000, enc_i(0, 5'd1, 5'd5, LOAD));
    @(negedge clk);
    present(32'h0000_3004, add_inst);
    #1;
    check_bit(id_stall, 1'b1, "stall on LOAD x5");
    @(negedge clk);
    check_bundle(ex, bubble(), "bubble after LOAD x5");
    #1;
    check_bit(id_stall, 1'b0, "stall released");
    @(negedge clk);
    check_word(ex.inst, add_inst, "ADD after stall");
    check_word(ex.rd1, int_model[5], "ADD rd1 after stall");
    present(32'h0000_3008, enc_i(0, 5'd1, 5'd9, LOAD_FP));
    @(negedge clk);
    present(32'h0000_300c, fma_inst);
    #1;
    check_bit(id_stall, 1'b1, "stall on LOAD_FP f9");
    @(negedge clk);
    check_bundle(ex, bubble(), "bubble after LOAD_FP f9");
    @(negedge clk);
    check_word(ex.inst, fma_inst, "FMADD after stall");
    present(32'h0000_3010, enc_i(0, 5'd1, 5'd0, LOAD));
    @(negedge clk);
    present(32'h0000_3014, enc_r(5'd0, 5'd0, 5'd6, OP));
    #1;
    check_bit(id_stall, 1'b0, "no stall on LOAD x0");
    @(negedge clk);
endtask

task automatic test_backpressure_flush();
    logic [31:0] first;
    logic [31:0] second;
    first  = enc_i(3, 5'd2, 5'd1, OP_IMM);
    second = enc_i(9, 5'd5, 5'd4, OP_IMM);
    present(32'h0000_0300, first);
    @(negedge clk);
    ex_stall = 1'b1;
    present(32'h0000_0304, second);
    repeat (3) begin
        @(negedge clk);
        check_bundle(ex, expect_bundle(32'h0000_0300, first, 3, 1'b0), "held under ex_stall");
    end
    // Flush wins over the held bundle
    mem_flush = 1'b1;
    @(negedge clk);
    check_bundle(ex, bubble(), "flush during ex_stall");
    mem_flush = 1'b0;
    ex_stall  = 1'b0;
    @(negedge clk);
    check_bundle(ex, expect_bundle(32'h0000_0304, second, 9, 1'b0), "load after release");
endtask

`endif

/* tb/tb_decode.sv */
module tb_decode;

    import decode_pkg::*;

    // Six tests of at most 200 cycles each, plus the reset phase
    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 16;
    localparam int WATCHDOG_TIME = (RESET_CYCLES + 6 * 200) * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    logic        mem_flush;
    logic        ex_stall;
    logic [31:0] id_pc;
    logic [31:0] id_bios_inst;
    logic [31:0] id_imem_inst;
    wb_t         wb;
    logic [31:0] id_target;
    logic        id_target_taken;
    logic        id_stall;
    id_ex_t      ex;

    // Reference copies of both register files
    logic [31:0] int_model [32];
    logic [31:0] fp_model [32];

    int seed;
    int errors;
    int checks;

    id_stage #(
        .BOOT_SEL_BIT (30)
    ) dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_flush       (mem_flush),
        .ex_stall        (ex_stall),
        .id_pc           (id_pc),
        .id_bios_inst    (id_bios_inst),
        .id_imem_inst    (id_imem_inst),
        .wb              (wb),
        .id_target       (id_target),
        .id_target_taken (id_target_taken),
        .id_stall        (id_stall),
        .ex              (ex)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_bundle(input id_ex_t got, input id_ex_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    `include "tb_decode_tests.svh"

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the tests did not finish within %0d time units", WATCHDOG_TIME);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        seed         = 41494;
        errors       = 0;
        checks       = 0;
        rst_n        = 1'b0;
        mem_flush    = 1'b0;
        ex_stall     = 1'b0;
        id_pc        = 32'd0;
        id_bios_inst = 32'd0;
        id_imem_inst = 32'd0;
        wb           = '0;
        for (int i = 0; i < 32; i++) begin
            int_model[i] = 32'd0;
            fp_model[i]  = 32'd0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        test_reset_and_regs();
        test_immediates();
        test_targets();
        test_inst_source();
        test_load_use();
        test_backpressure_flush();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+tb
verilog/decode_pkg.sv
verilog/reg_file.sv
verilog/fp_reg_file.sv
verilog/imm_gen.sv
verilog/target_gen.sv
verilog/id_control.sv
verilog/id_stage.sv
tb/tb_decode.sv

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_decode -o sim_decode \
    > build.log 2>&1 \
    || { cat build.log; echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_decode > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation did not complete, see sim.log"; exit 1; }

cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0
